/* hdl/llbank_defs.svh */
/*
  Size macros for the message bank: identifier width,
  number of shared slots and full message width
*/

`ifndef LLBANK_DEFS_SVH
`define LLBANK_DEFS_SVH

// Identifier bits at the low end of a message
`define LLB_ID_WIDTH 2

// Slots shared by all identifiers
`define LLB_CAPACITY 16

// Payload plus identifier
`define LLB_MSG_WIDTH 10

`endif

/* hdl/llbank_pkg.sv */
/*
  Shared types of the message bank: identifier, slot address,
  payload, full message and the per-identifier mask
*/

`include "llbank_defs.svh"

package llbank_pkg;

  typedef logic [`LLB_ID_WIDTH-1:0] id_t;

  typedef logic [$clog2(`LLB_CAPACITY)-1:0] addr_t;

  typedef logic [`LLB_MSG_WIDTH-`LLB_ID_WIDTH-1:0] payload_t;

  // Identifier occupies the low bits
  typedef struct packed {
    payload_t payload;
    id_t      id;
  } msg_t;

  // One bit per identifier
  typedef logic [2**`LLB_ID_WIDTH-1:0] id_mask_t;

endpackage

/* hdl/link_ram.sv */
/*
  Single-clock storage array with one write port and
  one registered read port
*/

`timescale 1ns/1ps
`include "llbank_defs.svh"

module link_ram #(
  parameter int Width = 8
) (
  input  logic              clk_i,
  input  logic              we_i,
  input  llbank_pkg::addr_t waddr_i,
  input  logic [Width-1:0]  wdata_i,
  input  logic              re_i,
  input  llbank_pkg::addr_t raddr_i,
  output logic [Width-1:0]  rdata_o
);

  logic [Width-1:0] mem_q [`LLB_CAPACITY];

  // Write lands at the edge
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Read data held until the next strobe
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

/* hdl/slot_allocator.sv */
/*
  Occupancy map of the shared slots with set and clear strobes
  and a search for the lowest free slot
*/

`timescale 1ns/1ps
`include "llbank_defs.svh"

module slot_allocator (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              set_i,
  input  logic              clr_i,
  input  llbank_pkg::addr_t set_addr_i,
  input  llbank_pkg::addr_t clr_addr_i,
  output llbank_pkg::addr_t free_addr_o,
  output logic              any_free_o
);
  import llbank_pkg::*;

  logic [`LLB_CAPACITY-1:0] occupied_d;
  logic [`LLB_CAPACITY-1:0] occupied_q;

  // Written slot becomes taken, read slot is released
  always_comb begin
    occupied_d = occupied_q;
    if (clr_i) begin
      occupied_d[clr_addr_i] = 1'b0;
    end
    if (set_i) begin
      occupied_d[set_addr_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= occupied_d;
    end
  end

  // Scan downwards so the lowest free slot wins
  always_comb begin
    free_addr_o = '0;
    for (int i = `LLB_CAPACITY - 1; i >= 0; i--) begin
      if (!occupied_q[i]) begin
        free_addr_o = addr_t'(i);
      end
    end
  end

  assign any_free_o = !(&occupied_q);

endmodule

/* hdl/id_list_ctrl.sv */
/*
  List state of one identifier: head, tail, length and the
  one-entry output buffer, with the memory and slot requests
*/

`timescale 1ns/1ps
`include "llbank_defs.svh"

module id_list_ctrl #(
  parameter int Id = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 accept_i,
  input  llbank_pkg::id_t      in_id_i,
  input  llbank_pkg::payload_t in_payload_i,
  input  logic                 grant_i,
  input  logic                 out_ready_i,
  input  llbank_pkg::addr_t    free_addr_i,
  input  llbank_pkg::payload_t ram_payload_i,
  input  llbank_pkg::addr_t    ram_next_i,
  output logic                 buf_valid_o,
  output llbank_pkg::payload_t buf_data_o,
  output logic                 pay_we_o,
  output llbank_pkg::addr_t    pay_waddr_o,
  output logic                 nxt_we_o,
  output llbank_pkg::addr_t    nxt_waddr_o,
  output logic                 rd_o,
  output llbank_pkg::addr_t    rd_addr_o,
  output logic                 slot_set_o,
  output logic                 slot_clr_o,
  output llbank_pkg::addr_t    slot_clr_addr_o
);
  import llbank_pkg::*;

  localparam int LenWidth = $clog2(`LLB_CAPACITY + 1);

  addr_t                head_d, head_q, head_act;
  addr_t                tail_d, tail_q;
  logic [LenWidth-1:0]  len_d, len_q;
  logic                 head_from_mem_d, head_from_mem_q;
  payload_t             buf_d, buf_q, buf_act;
  logic                 buf_valid_d, buf_valid_q;
  logic                 buf_from_mem_d, buf_from_mem_q;

  logic my_in;
  logic pop;
  logic list_busy;
  logic rd;
  logic append;
  logic new_list;

  // Head and buffer follow the memory output for one cycle after a read
  assign head_act = head_from_mem_q ? ram_next_i : head_q;
  assign buf_act  = buf_from_mem_q ? ram_payload_i : buf_q;

  assign my_in     = accept_i && (in_id_i == id_t'(Id));
  assign pop       = grant_i && out_ready_i;
  assign list_busy = (len_q != '0);

  // Refill the buffer from the list head
  assign rd = pop && buf_valid_q && list_busy;

  // Input goes to the list unless the buffer can take it
  assign append   = my_in && buf_valid_q && !(pop && !list_busy);
  assign new_list = (len_q == '0) || (len_q == LenWidth'(1) && pop);

  always_comb begin
    head_d          = head_act;
    tail_d          = tail_q;
    len_d           = len_q;
    head_from_mem_d = 1'b0;
    buf_d           = buf_act;
    buf_valid_d     = buf_valid_q;
    buf_from_mem_d  = 1'b0;

    // Output side first
    if (pop && buf_valid_q) begin
      if (list_busy) begin
        head_from_mem_d = 1'b1;
        buf_from_mem_d  = 1'b1;
        len_d           = len_d - LenWidth'(1);
      end else if (my_in) begin
        buf_d = in_payload_i;
      end else begin
        buf_valid_d = 1'b0;
      end
    end

    // Empty buffer takes the input unless it passes straight through
    if (my_in && !buf_valid_q && !pop) begin
      buf_valid_d = 1'b1;
      buf_d       = in_payload_i;
    end

    if (append) begin
      len_d  = len_d + LenWidth'(1);
      tail_d = free_addr_i;
      if (new_list) begin
        head_d          = free_addr_i;
        head_from_mem_d = 1'b0;
      end
    end
  end

  always_comb begin
    pay_we_o        = append;
    pay_waddr_o     = '0;
    nxt_we_o        = append && !new_list;
    nxt_waddr_o     = '0;
    rd_o            = rd;
    rd_addr_o       = '0;
    slot_set_o      = append;
    slot_clr_o      = rd;
    slot_clr_addr_o = '0;
    if (append) begin
      pay_waddr_o = free_addr_i;
    end
    // Old tail points to the new slot
    if (append && !new_list) begin
      nxt_waddr_o = tail_q;
    end
    if (rd) begin
      rd_addr_o       = head_act;
      slot_clr_addr_o = head_act;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_q           <= '0;
      head_from_mem_q <= 1'b0;
      buf_valid_q     <= 1'b0;
      buf_from_mem_q  <= 1'b0;
    end else begin
      len_q           <= len_d;
      head_from_mem_q <= head_from_mem_d;
      buf_valid_q     <= buf_valid_d;
      buf_from_mem_q  <= buf_from_mem_d;
    end
  end

  always_ff @(posedge clk_i) begin
    head_q <= head_d;
    tail_q <= tail_d;
    buf_q  <= buf_d;
  end

  assign buf_valid_o = buf_valid_q;
  assign buf_data_o  = buf_act;

endmodule

/* hdl/release_arbiter.sv */
/*
  Lowest-enabled-identifier grant and the merge of the
  granted buffer or input payload into the output message
*/

`timescale 1ns/1ps
`include "llbank_defs.svh"

module release_arbiter (
  input  llbank_pkg::id_mask_t buf_valid_i,
  input  logic                 accept_i,
  input  llbank_pkg::id_t      in_id_i,
  input  llbank_pkg::id_mask_t release_en_i,
  input  llbank_pkg::payload_t buf_data_i [2**`LLB_ID_WIDTH],
  input  llbank_pkg::payload_t in_payload_i,
  output llbank_pkg::id_mask_t grant_o,
  output llbank_pkg::msg_t     out_msg_o,
  output logic                 out_valid_o
);
  import llbank_pkg::*;

  localparam int NumIds = 2 ** `LLB_ID_WIDTH;

  id_mask_t in_hit;
  id_mask_t eligible;

  always_comb begin
    in_hit = '0;
    if (accept_i) begin
      in_hit[in_id_i] = 1'b1;
    end
  end

  assign eligible = (buf_valid_i | in_hit) & release_en_i;

  // Isolate the lowest set bit
  assign grant_o     = eligible & (~eligible + id_mask_t'(1));
  assign out_valid_o = |eligible;

  // Empty buffer means the input passes through
  always_comb begin
    out_msg_o = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (grant_o[i]) begin
        out_msg_o.id      = id_t'(i);
        out_msg_o.payload = buf_valid_i[i] ? buf_data_i[i] : in_payload_i;
      end
    end
  end

endmodule

/* hdl/llbank_top.sv */
/*
  Linked-list message bank: per-identifier list controllers,
  slot allocator, release arbiter and the payload and pointer memories
*/

`timescale 1ns/1ps
`include "llbank_defs.svh"

module llbank_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  llbank_pkg::msg_t     in_msg_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  llbank_pkg::id_mask_t release_en_i,
  output llbank_pkg::msg_t     out_msg_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);
  import llbank_pkg::*;

  localparam int NumIds = 2 ** `LLB_ID_WIDTH;

  logic     accept;
  addr_t    free_addr;
  logic     any_free;
  id_mask_t grant;

  id_mask_t buf_valid;
  payload_t buf_data [NumIds];
  id_mask_t pay_we, nxt_we, rd, slot_set, slot_clr;
  addr_t    pay_waddr [NumIds];
  addr_t    nxt_waddr [NumIds];
  addr_t    rd_addr [NumIds];
  addr_t    clr_addr [NumIds];

  addr_t    pay_waddr_m, nxt_waddr_m, rd_addr_m, clr_addr_m;
  payload_t ram_payload;
  addr_t    ram_next;

  // Room in the pool or an empty buffer somewhere
  assign in_ready_o = any_free || !(&buf_valid);
  assign accept     = in_valid_i && in_ready_o;

  for (genvar i = 0; i < NumIds; i++) begin : g_ctrl
    id_list_ctrl #(
      .Id(i)
    ) u_ctrl (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .accept_i        (accept),
      .in_id_i         (in_msg_i.id),
      .in_payload_i    (in_msg_i.payload),
      .grant_i         (grant[i]),
      .out_ready_i     (out_ready_i),
      .free_addr_i     (free_addr),
      .ram_payload_i   (ram_payload),
      .ram_next_i      (ram_next),
      .buf_valid_o     (buf_valid[i]),
      .buf_data_o      (buf_data[i]),
      .pay_we_o        (pay_we[i]),
      .pay_waddr_o     (pay_waddr[i]),
      .nxt_we_o        (nxt_we[i]),
      .nxt_waddr_o     (nxt_waddr[i]),
      .rd_o            (rd[i]),
      .rd_addr_o       (rd_addr[i]),
      .slot_set_o      (slot_set[i]),
      .slot_clr_o      (slot_clr[i]),
      .slot_clr_addr_o (clr_addr[i])
    );
  end

  // At most one writer and one reader per cycle, so OR is enough
  always_comb begin
    pay_waddr_m = '0;
    nxt_waddr_m = '0;
    rd_addr_m   = '0;
    clr_addr_m  = '0;
    for (int i = 0; i < NumIds; i++) begin
      pay_waddr_m = pay_waddr_m | pay_waddr[i];
      nxt_waddr_m = nxt_waddr_m | nxt_waddr[i];
      rd_addr_m   = rd_addr_m | rd_addr[i];
      clr_addr_m  = clr_addr_m | clr_addr[i];
    end
  end

  slot_allocator u_alloc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .set_i       (|slot_set),
    .clr_i       (|slot_clr),
    .set_addr_i  (pay_waddr_m),
    .clr_addr_i  (clr_addr_m),
    .free_addr_o (free_addr),
    .any_free_o  (any_free)
  );

  release_arbiter u_arb (
    .buf_valid_i  (buf_valid),
    .accept_i     (accept),
    .in_id_i      (in_msg_i.id),
    .release_en_i (release_en_i),
    .buf_data_i   (buf_data),
    .in_payload_i (in_msg_i.payload),
    .grant_o      (grant),
    .out_msg_o    (out_msg_o),
    .out_valid_o  (out_valid_o)
  );

  link_ram #(
    .Width($bits(payload_t))
  ) u_payload_ram (
    .clk_i   (clk_i),
    .we_i    (|pay_we),
    .waddr_i (pay_waddr_m),
    .wdata_i (in_msg_i.payload),
    .re_i    (|rd),
    .raddr_i (rd_addr_m),
    .rdata_o (ram_payload)
  );

  // Next pointer of the old tail is the slot taken now
  link_ram #(
    .Width($bits(addr_t))
  ) u_next_ram (
    .clk_i   (clk_i),
    .we_i    (|nxt_we),
    .waddr_i (nxt_waddr_m),
    .wdata_i (free_addr),
    .re_i    (|rd),
    .raddr_i (rd_addr_m),
    .rdata_o (ram_next)
  );

endmodule

/* sim/llbank_tb.sv */
/*
  Testbench for the message bank: stimulus from a data file,
  per-identifier reference queues, compare tasks and a watchdog
*/

`timescale 1ns/1ps
`include "llbank_defs.svh"

module llbank_tb;
  import llbank_pkg::*;

  localparam int clk_period   = 20;
  localparam int reset_cycles = 5;
  localparam int drive_delay  = 2;
  localparam int num_ids      = 2 ** `LLB_ID_WIDTH;
  localparam int model_depth  = 32;

  // One cycle of stimulus as read from the data file
  typedef struct packed {
    id_mask_t release_en;
    logic     in_valid;
    msg_t     in_msg;
    logic     out_ready;
  } stim_t;

  logic     clk;
  logic     rst_n;
  msg_t     in_msg;
  logic     in_valid;
  logic     in_ready;
  id_mask_t release_en;
  msg_t     out_msg;
  logic     out_valid;
  logic     out_ready;

  stim_t    stim_q [$];
  logic     stim_loaded;

  // Reference model with one ring of messages per identifier
  payload_t model_mem [num_ids][model_depth];
  int       model_head [num_ids];
  int       model_cnt [num_ids];

  llbank_top UUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .in_msg_i     (in_msg),
    .in_valid_i   (in_valid),
    .in_ready_o   (in_ready),
    .release_en_i (release_en),
    .out_msg_o    (out_msg),
    .out_valid_o  (out_valid),
    .out_ready_i  (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_msg(input string name, input msg_t exp, input msg_t act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s expected id %0d payload %h actual id %0d payload %h",
                         name, exp.id, exp.payload, act.id, act.payload));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic model_push(input id_t id, input payload_t payload);
    int slot;
    slot = (model_head[id] + model_cnt[id]) % model_depth;
    model_mem[id][slot] = payload;
    model_cnt[id] = model_cnt[id] + 1;
  endtask

  task automatic model_pop(input int id);
    model_head[id] = (model_head[id] + 1) % model_depth;
    model_cnt[id]  = model_cnt[id] - 1;
  endtask

  task automatic load_stimulus();
    int    fd;
    int    n;
    int    mask, valid, id, pay, ready;
    string line;
    logic  is_comment;
    stim_t s;
    fd = $fopen("sim/llbank_input.txt", "r");
    if (fd == 0) begin
      stop_run("Stimulus file sim/llbank_input.txt could not be opened");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        is_comment = (line.len() >= 2) && (line.substr(0, 1) == "//");
        if (!is_comment) begin
          n = $sscanf(line, "%h %h %h %h %h", mask, valid, id, pay, ready);
          if (n == 5) begin
            s.release_en     = id_mask_t'(mask);
            s.in_valid       = valid[0];
            s.in_msg.id      = id_t'(id);
            s.in_msg.payload = payload_t'(pay);
            s.out_ready      = ready[0];
            stim_q.push_back(s);
          end else if (n > 0) begin
            stop_run($sformatf("Stimulus line could not be read: %s", line));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_stim(input stim_t s);
    release_en = s.release_en;
    in_valid   = s.in_valid;
    in_msg     = s.in_msg;
    out_ready  = s.out_ready;
  endtask

  // Expected outputs of one cycle, then the model takes the handshakes
  task automatic check_cycle(input stim_t s, input int idx);
    int   used;
    int   win;
    logic empty_seen;
    logic ready_exp;
    msg_t msg_exp;
    used       = 0;
    empty_seen = 1'b0;
    // Oldest message of each identifier sits in its buffer, the rest in slots
    for (int i = 0; i < num_ids; i++) begin
      if (model_cnt[i] == 0) begin
        empty_seen = 1'b1;
      end else begin
        used = used + model_cnt[i] - 1;
      end
    end
    ready_exp = (used < `LLB_CAPACITY) || empty_seen;
    check_flag($sformatf("cycle %0d in_ready", idx), ready_exp, in_ready);
    if (s.in_valid && ready_exp) begin
      model_push(s.in_msg.id, s.in_msg.payload);
    end
    // Lowest enabled identifier with a message wins
    win = -1;
    for (int i = num_ids - 1; i >= 0; i--) begin
      if (s.release_en[i] && model_cnt[i] > 0) begin
        win = i;
      end
    end
    check_flag($sformatf("cycle %0d out_valid", idx), win >= 0, out_valid);
    if (win >= 0) begin
      msg_exp.id      = id_t'(win);
      msg_exp.payload = model_mem[win][model_head[win]];
      check_msg($sformatf("cycle %0d out_msg", idx), msg_exp, out_msg);
      if (s.out_ready) begin
        model_pop(win);
      end
    end
  endtask

  initial begin
    in_msg      = '0;
    in_valid    = 1'b0;
    release_en  = '0;
    out_ready   = 1'b0;
    rst_n       = 1'b0;
    stim_loaded = 1'b0;
    for (int i = 0; i < num_ids; i++) begin
      model_head[i] = 0;
      model_cnt[i]  = 0;
    end
    load_stimulus();
    if (stim_q.size() == 0) begin
      stop_run("Stimulus file holds no stimulus lines");
    end
    stim_loaded = 1'b1;

    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;
    #(clk_period - 2 * drive_delay);
    check_flag("after reset out_valid", 1'b0, out_valid);
    check_flag("after reset in_ready", 1'b1, in_ready);

    for (int i = 0; i < stim_q.size(); i++) begin
      @(posedge clk);
      #(drive_delay);
      apply_stim(stim_q[i]);
      // Sample just before the next rising edge
      #(clk_period - 2 * drive_delay);
      check_cycle(stim_q[i], i);
    end

    $display("Verification passed");
    $finish;
  end

  // Twice the stimulus length plus the reset time
  initial begin
    wait (stim_loaded === 1'b1);
    #(stim_q.size() * clk_period * 2 + reset_cycles * clk_period);
    stop_run("Timeout: the run did not finish within the time allowed for the stimulus");
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/llbank_pkg.sv
hdl/link_ram.sv
hdl/slot_allocator.sv
hdl/id_list_ctrl.sv
hdl/release_arbiter.sv
hdl/llbank_top.sv
sim/llbank_tb.sv

/* Makefile */
# Verilator build and run of the linked-list message bank testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module llbank_tb -f vlog.f -o llbank_sim
	@out="$$(./obj_dir/llbank_sim)"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* sim/llbank_input.txt */
// Columns (hex): release mask, in_valid, identifier, payload, out_ready
// One line per clock cycle after reset
f 0 0 00 1
f 1 1 a1 1
f 1 2 b1 0
f 1 2 b2 0
f 1 2 b3 0
f 0 0 00 1
f 1 2 b4 1
f 1 2 b5 1
f 0 0 00 1
f 0 0 00 1
e 1 0 c1 1
e 1 0 c2 1
e 1 3 d1 1
e 1 0 c3 1
c 1 1 a2 1
1 1 3 d2 0
3 1 0 c4 1
3 1 1 a3 1
2 0 0 00 1
2 0 0 00 0
2 0 0 00 1
f 0 0 00 1
f 0 0 00 1
f 0 0 00 1
f 1 1 e0 0
f 1 1 e1 0
f 1 1 e2 0
f 1 2 f0 0
f 1 2 f1 0
f 1 1 e3 1
f 1 1 e4 1
f 1 2 f2 1
4 1 1 e5 1
f 0 0 00 1
f 0 0 00 1
f 0 0 00 1
f 0 0 00 1
f 0 0 00 1
f 0 0 00 1
